// ==== src/csr_pkg.sv ====
////////////////////
// csr package
// shared csr op type, machine csr addresses,
// writable-bit masks and the system opcode
////////////////////

package csr_pkg;

    // csr operation after decode, immediate forms fold into the same three
    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,  // no csr op this cycle
        CSR_RW   = 2'd1,  // write
        CSR_RS   = 2'd2,  // set bits
        CSR_RC   = 2'd3   // clear bits
    } csr_op_e;

    // fixed by the isa
    localparam int CSR_ADDR_W = 12;

    // machine-mode csr addresses
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;

    // writable bits per csr
    // mstatus: mie (3) and mpie (7) only
    localparam logic [31:0] MASK_MSTATUS = 32'h0000_0088;
    // mie: msie, mtie, meie
    localparam logic [31:0] MASK_MIE     = 32'h0000_0888;
    // mtvec base is word aligned, mode bits tied to direct
    localparam logic [31:0] MASK_MTVEC   = 32'hffff_fffc;
    // no compressed support so epc stays word aligned
    localparam logic [31:0] MASK_MEPC    = 32'hffff_fffc;

    // major opcode of csr and other system instructions
    localparam logic [6:0] OPC_SYSTEM = 7'h73;

endpackage

// ==== src/csr_req_if.sv ====
////////////////////
// csr request bundle
// one decoded csr op, decoder to execution unit
////////////////////

interface csr_req_if #(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
);

    logic                              valid;     // csr instruction present
    csr_pkg::csr_op_e                  op;        // write / set / clear
    logic [DATA_W-1:0]                 op1;       // rs1 data or zimm
    logic [csr_pkg::CSR_ADDR_W-1:0]    csr_addr;  // target csr
    logic [REG_ADDR_W-1:0]             rd;        // write-back register
    logic                              csr_we;    // csr gets written
    logic                              reg_we;    // rd gets old value

    // decoder side
    modport src (
        output valid, op, op1, csr_addr, rd, csr_we, reg_we
    );

    // execution unit side
    modport dst (
        input valid, op, op1, csr_addr, rd, csr_we, reg_we
    );

endinterface

// ==== src/csr_decode.sv ====
////////////////////
// csr decoder
// zicsr instruction to csr request, purely combinational
////////////////////

module csr_decode #(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    input  logic [DATA_W-1:0] rs1_data_i,
    csr_req_if.src            req
);

    // funct3 codes of the six csr instructions
    typedef enum logic [2:0] {
        F3_CSRRW  = 3'b001,
        F3_CSRRS  = 3'b010,
        F3_CSRRC  = 3'b011,
        F3_CSRRWI = 3'b101,
        F3_CSRRSI = 3'b110,
        F3_CSRRCI = 3'b111
    } funct3_e;

    logic [6:0]                     opcode;
    funct3_e                        funct3;
    logic [4:0]                     src_field;  // rs1 index or zimm
    logic [REG_ADDR_W-1:0]          rd_field;
    logic [csr_pkg::CSR_ADDR_W-1:0] csr_field;
    logic                           imm_form;   // funct3 5..7
    logic                           is_csr;     // funct3 is a csr code
    csr_pkg::csr_op_e               op_dec;
    logic                           valid;

    // instruction fields
    assign opcode    = instr_i[6:0];
    assign funct3    = funct3_e'(instr_i[14:12]);
    assign src_field = instr_i[19:15];
    assign rd_field  = instr_i[7 +: REG_ADDR_W];
    assign csr_field = instr_i[31:20];
    assign imm_form  = instr_i[14];

    always_comb begin
        is_csr = 1'b1;
        op_dec = csr_pkg::CSR_NONE;
        case (funct3)
            F3_CSRRW, F3_CSRRWI: op_dec = csr_pkg::CSR_RW;
            F3_CSRRS, F3_CSRRSI: op_dec = csr_pkg::CSR_RS;
            F3_CSRRC, F3_CSRRCI: op_dec = csr_pkg::CSR_RC;
            default:             is_csr = 1'b0;  // ecall/ebreak/mret space, not ours
        endcase
    end

    assign valid = instr_valid_i & (opcode == csr_pkg::OPC_SYSTEM) & is_csr;

    assign req.valid    = valid;
    assign req.op       = valid ? op_dec : csr_pkg::CSR_NONE;
    assign req.op1      = imm_form ? DATA_W'(src_field) : rs1_data_i;  // zimm zero-extended
    assign req.csr_addr = csr_field;
    assign req.rd       = rd_field;

    // set/clear with x0 or zimm of 0 must not write the csr
    assign req.csr_we = valid & ((op_dec == csr_pkg::CSR_RW) | (src_field != 5'd0));
    assign req.reg_we = valid & (rd_field != '0);  // rd = x0 drops write-back

endmodule

// ==== src/csr_regfile.sv ====
////////////////////
// machine csr file
// six m-mode csrs, masked writes,
// async read with bypass of the pending write
////////////////////

module csr_regfile #(
    parameter int DATA_W = 32
) (
    input  logic                           clk,
    input  logic                           reset_i,
    // read port
    input  logic [csr_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [DATA_W-1:0]              rdata_o,
    // write port, from the registered exu outputs
    input  logic                           we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] waddr_i,
    input  logic [DATA_W-1:0]              wdata_i
);

    logic [DATA_W-1:0] mstatus_q;
    logic [DATA_W-1:0] mie_q;
    logic [DATA_W-1:0] mtvec_q;
    logic [DATA_W-1:0] mscratch_q;
    logic [DATA_W-1:0] mepc_q;
    logic [DATA_W-1:0] mcause_q;

    logic [DATA_W-1:0] wmask;     // writable bits of the write target
    logic [DATA_W-1:0] wdata_m;   // write data after masking
    logic [DATA_W-1:0] rd_array;  // stored value at raddr
    logic              bypass;

    // per-address write mask, zero for unknown csrs
    always_comb begin
        case (waddr_i)
            csr_pkg::ADDR_MSTATUS:  wmask = DATA_W'(csr_pkg::MASK_MSTATUS);
            csr_pkg::ADDR_MIE:      wmask = DATA_W'(csr_pkg::MASK_MIE);
            csr_pkg::ADDR_MTVEC:    wmask = DATA_W'(csr_pkg::MASK_MTVEC);
            csr_pkg::ADDR_MSCRATCH: wmask = '1;  // fully writable
            csr_pkg::ADDR_MEPC:     wmask = DATA_W'(csr_pkg::MASK_MEPC);
            csr_pkg::ADDR_MCAUSE:   wmask = '1;
            default:                wmask = '0;
        endcase
    end

    assign wdata_m = wdata_i & wmask;

    // storage, one write per edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (we_i) begin
            case (waddr_i)
                csr_pkg::ADDR_MSTATUS:  mstatus_q  <= wdata_m;
                csr_pkg::ADDR_MIE:      mie_q      <= wdata_m;
                csr_pkg::ADDR_MTVEC:    mtvec_q    <= wdata_m;
                csr_pkg::ADDR_MSCRATCH: mscratch_q <= wdata_m;
                csr_pkg::ADDR_MEPC:     mepc_q     <= wdata_m;
                csr_pkg::ADDR_MCAUSE:   mcause_q   <= wdata_m;
                default: ;  // unknown csr, write dropped
            endcase
        end
    end

    // read mux
    always_comb begin
        case (raddr_i)
            csr_pkg::ADDR_MSTATUS:  rd_array = mstatus_q;
            csr_pkg::ADDR_MIE:      rd_array = mie_q;
            csr_pkg::ADDR_MTVEC:    rd_array = mtvec_q;
            csr_pkg::ADDR_MSCRATCH: rd_array = mscratch_q;
            csr_pkg::ADDR_MEPC:     rd_array = mepc_q;
            csr_pkg::ADDR_MCAUSE:   rd_array = mcause_q;
            default:                rd_array = '0;  // unknown reads as zero
        endcase
    end

    // write lands one edge late, so a back-to-back op on the same csr
    // must see the pending data
    assign bypass  = we_i & (waddr_i == raddr_i);
    assign rdata_o = bypass ? wdata_m : rd_array;  // masked, unknown stays zero

endmodule

// ==== src/exu_csr_unit.sv ====
////////////////////
// csr execution unit
// write/set/clear of the csr value, old value as
// write-back, output stage held by wb_ready_i
////////////////////

module exu_csr_unit #(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                           clk,
    input  logic                           reset_i,
    csr_req_if.dst                         req,
    // csr file read port
    output logic [csr_pkg::CSR_ADDR_W-1:0] csr_raddr_o,
    input  logic [DATA_W-1:0]              csr_rdata_i,
    // control
    input  logic                           int_assert_i,  // cancels this cycle's op
    input  logic                           wb_ready_i,    // write-back can take a result
    output logic                           csr_stall_o,
    // csr file write port
    output logic [DATA_W-1:0]              csr_wdata_o,
    output logic                           csr_we_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0] csr_waddr_o,
    // general register write-back
    output logic [DATA_W-1:0]              reg_wdata_o,
    output logic [REG_ADDR_W-1:0]          reg_waddr_o,
    output logic                           reg_we_o
);

    logic [DATA_W-1:0] csr_wdata_nxt;
    logic [DATA_W-1:0] reg_wdata_nxt;
    logic              csr_we_nxt;
    logic              reg_we_nxt;

    assign csr_raddr_o = req.csr_addr;  // read the target csr straight away

    // next csr value and write-back value
    always_comb begin
        csr_wdata_nxt = '0;
        reg_wdata_nxt = '0;
        csr_we_nxt    = 1'b0;
        reg_we_nxt    = 1'b0;
        if (!int_assert_i && req.valid) begin  // interrupt wins, everything zero
            reg_wdata_nxt = csr_rdata_i;  // old value goes to rd
            csr_we_nxt    = req.csr_we;
            reg_we_nxt    = req.reg_we;
            case (req.op)
                csr_pkg::CSR_RW: csr_wdata_nxt = req.op1;
                csr_pkg::CSR_RS: csr_wdata_nxt = csr_rdata_i | req.op1;
                csr_pkg::CSR_RC: csr_wdata_nxt = csr_rdata_i & ~req.op1;
                default:         csr_wdata_nxt = '0;
            endcase
        end
    end

    // output stage, loads every ready cycle, idle result included
    always_ff @(posedge clk) begin
        if (reset_i) begin
            csr_wdata_o <= '0;
            csr_we_o    <= 1'b0;
            csr_waddr_o <= '0;
            reg_wdata_o <= '0;
            reg_waddr_o <= '0;
            reg_we_o    <= 1'b0;
        end else if (wb_ready_i) begin
            csr_wdata_o <= csr_wdata_nxt;
            csr_we_o    <= csr_we_nxt;
            csr_waddr_o <= req.csr_addr;  // addresses pass through as is
            reg_wdata_o <= reg_wdata_nxt;
            reg_waddr_o <= req.rd;
            reg_we_o    <= reg_we_nxt;
        end
    end

    // held csr write while write-back is not ready
    assign csr_stall_o = csr_we_o & ~wb_ready_i;

endmodule

// ==== src/csr_top.sv ====
////////////////////
// csr slice top
// decoder, csr file and csr execution unit
////////////////////

module csr_top #(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  reset_i,
    // instruction side
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [DATA_W-1:0]     rs1_data_i,
    input  logic                  int_assert_i,
    // write-back side
    input  logic                  wb_ready_i,
    output logic [DATA_W-1:0]     reg_wdata_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o,
    output logic                  reg_we_o,
    output logic                  csr_stall_o
);

    // csr file read port
    logic [csr_pkg::CSR_ADDR_W-1:0] csr_raddr;
    logic [DATA_W-1:0]              csr_rdata;

    // csr file write port, registered in the exu
    logic                           csr_we;
    logic [csr_pkg::CSR_ADDR_W-1:0] csr_waddr;
    logic [DATA_W-1:0]              csr_wdata;

    // decoded request
    csr_req_if #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_req ();

    csr_decode #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .req           (u_req)
    );

    csr_regfile #(
        .DATA_W (DATA_W)
    ) u_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .raddr_i (csr_raddr),
        .rdata_o (csr_rdata),
        .we_i    (csr_we),
        .waddr_i (csr_waddr),
        .wdata_i (csr_wdata)
    );

    exu_csr_unit #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_exu (
        .clk          (clk),
        .reset_i      (reset_i),
        .req          (u_req),
        .csr_raddr_o  (csr_raddr),
        .csr_rdata_i  (csr_rdata),
        .int_assert_i (int_assert_i),
        .wb_ready_i   (wb_ready_i),
        .csr_stall_o  (csr_stall_o),
        .csr_wdata_o  (csr_wdata),
        .csr_we_o     (csr_we),
        .csr_waddr_o  (csr_waddr),
        .reg_wdata_o  (reg_wdata_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_we_o     (reg_we_o)
    );

endmodule

// ==== tb/csr_tb.sv ====
////////////////////
// csr slice testbench
// stimulus table with model-derived expected values,
// applied one row per cycle to csr_top
////////////////////

module csr_tb;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // funct3 codes
    localparam logic [2:0] F3_RW  = 3'b001;
    localparam logic [2:0] F3_RS  = 3'b010;
    localparam logic [2:0] F3_RC  = 3'b011;
    localparam logic [2:0] F3_RWI = 3'b101;
    localparam logic [2:0] F3_RSI = 3'b110;
    localparam logic [2:0] F3_RCI = 3'b111;

    logic                  clk;
    logic                  reset_i;
    logic                  instr_valid_i;
    logic [31:0]           instr_i;
    logic [DATA_W-1:0]     rs1_data_i;
    logic                  int_assert_i;
    logic                  wb_ready_i;
    logic [DATA_W-1:0]     reg_wdata_o;
    logic [REG_ADDR_W-1:0] reg_waddr_o;
    logic                  reg_we_o;
    logic                  csr_stall_o;

    // stimulus columns
    string       row_name  [$];
    logic [31:0] row_instr [$];
    logic [31:0] row_rs1   [$];
    bit          row_vld   [$];
    bit          row_int   [$];
    bit          row_rdy   [$];
    // expected columns filled by the model
    logic [31:0] exp_wdata [$];
    logic [4:0]  exp_waddr [$];
    bit          exp_we    [$];
    bit          exp_stall [$];

    // reference csr state with slot 7 for any unknown csr
    logic [31:0] m_csr [8];
    logic [31:0] m_reg_wdata;
    logic [4:0]  m_reg_waddr;
    logic        m_reg_we;
    logic        m_csr_we;
    logic [11:0] m_csr_waddr;
    logic [31:0] m_csr_wdata;

    logic [31:0] lfsr;
    bit          table_done;
    int          cycles;
    int          cycle_limit;
    int          errors;
    int          checks;

    csr_top #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .int_assert_i  (int_assert_i),
        .wb_ready_i    (wb_ready_i),
        .reg_wdata_o   (reg_wdata_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_we_o      (reg_we_o),
        .csr_stall_o   (csr_stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = 32'd0;
        repeat (32) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            w = {lfsr[0], w[31:1]};
        end
    endtask

    function automatic logic [31:0] encode_csr(input logic [2:0] f3, input logic [11:0] a,
                                               input logic [4:0] src, input logic [4:0] rd);
        return {a, src, f3, rd, csr_pkg::OPC_SYSTEM};
    endfunction

    function automatic logic [2:0] csr_slot(input logic [11:0] a);
        case (a)
            csr_pkg::ADDR_MSTATUS:  return 3'd0;
            csr_pkg::ADDR_MIE:      return 3'd1;
            csr_pkg::ADDR_MTVEC:    return 3'd2;
            csr_pkg::ADDR_MSCRATCH: return 3'd3;
            csr_pkg::ADDR_MEPC:     return 3'd4;
            csr_pkg::ADDR_MCAUSE:   return 3'd5;
            default:                return 3'd7;
        endcase
    endfunction

    function automatic logic [31:0] csr_mask(input logic [11:0] a);
        case (a)
            csr_pkg::ADDR_MSTATUS:  return csr_pkg::MASK_MSTATUS;
            csr_pkg::ADDR_MIE:      return csr_pkg::MASK_MIE;
            csr_pkg::ADDR_MTVEC:    return csr_pkg::MASK_MTVEC;
            csr_pkg::ADDR_MEPC:     return csr_pkg::MASK_MEPC;
            csr_pkg::ADDR_MSCRATCH,
            csr_pkg::ADDR_MCAUSE:   return 32'hffff_ffff;
            default:                return 32'd0;  // nothing writable so reads zero
        endcase
    endfunction

    // ctl is {instr_valid, random rs1, int_assert, wb_ready}
    task automatic add_row(input string name, input logic [31:0] instr,
                           input logic [31:0] rs1, input logic [3:0] ctl);
        logic [31:0] data;
        data = rs1;
        if (ctl[2])
            random_word(data);
        row_name.push_back(name);
        row_instr.push_back(instr);
        row_rs1.push_back(data);
        row_vld.push_back(ctl[3]);
        row_int.push_back(ctl[1]);
        row_rdy.push_back(ctl[0]);
    endtask

    // one edge of the slice through decode, read, commit and output stage
    task automatic model_step(input int i);
        logic [31:0] ins;
        logic [4:0]  src;
        logic [11:0] a;
        logic        valid;
        logic [31:0] op1;
        logic [31:0] old;
        logic [31:0] nxt;
        logic        cwe;
        logic        rwe;
        ins   = row_instr[i];
        src   = ins[19:15];
        a     = ins[31:20];
        valid = row_vld[i] && (ins[6:0] == csr_pkg::OPC_SYSTEM) && (ins[13:12] != 2'b00);
        op1   = ins[14] ? {27'd0, src} : row_rs1[i];  // zimm forms
        if (m_csr_we && (m_csr_waddr == a))
            old = m_csr_wdata & csr_mask(a);  // write still in flight
        else
            old = m_csr[csr_slot(a)];
        case (ins[13:12])
            2'b01:   nxt = op1;
            2'b10:   nxt = old | op1;
            default: nxt = old & ~op1;
        endcase
        cwe = valid && ((ins[13:12] == 2'b01) || (src != 5'd0));
        rwe = valid && (ins[11:7] != 5'd0);
        if (!valid || row_int[i]) begin  // cancelled or not a csr op
            old = 32'd0;
            nxt = 32'd0;
            cwe = 1'b0;
            rwe = 1'b0;
        end
        if (m_csr_we)  // held write lands again with the same value
            m_csr[csr_slot(m_csr_waddr)] = m_csr_wdata & csr_mask(m_csr_waddr);
        if (row_rdy[i]) begin
            m_reg_wdata = old;
            m_reg_waddr = ins[11:7];
            m_reg_we    = rwe;
            m_csr_we    = cwe;
            m_csr_waddr = a;
            m_csr_wdata = nxt;
        end
        exp_wdata.push_back(m_reg_wdata);
        exp_waddr.push_back(m_reg_waddr);
        exp_we.push_back(m_reg_we);
        exp_stall.push_back(m_csr_we && !row_rdy[i]);
    endtask

    task automatic build_table();
        add_row("rw_mscratch", encode_csr(F3_RW, csr_pkg::ADDR_MSCRATCH, 5'd1, 5'd5),
                32'd0, 4'b1101);
        add_row("rs_mscratch_read", encode_csr(F3_RS, csr_pkg::ADDR_MSCRATCH, 5'd0, 5'd6),
                32'd0, 4'b1001);
        add_row("rw_mie", encode_csr(F3_RW, csr_pkg::ADDR_MIE, 5'd2, 5'd7),
                32'h0000_0880, 4'b1001);
        add_row("rsi_mie", encode_csr(F3_RSI, csr_pkg::ADDR_MIE, 5'h1f, 5'd8),
                32'd0, 4'b1001);  // only bit 3 survives the mask
        add_row("rc_mie", encode_csr(F3_RC, csr_pkg::ADDR_MIE, 5'd3, 5'd9),
                32'h0000_0080, 4'b1001);
        add_row("rs_mie_read", encode_csr(F3_RS, csr_pkg::ADDR_MIE, 5'd0, 5'd10),
                32'd0, 4'b1001);
        add_row("rw_mstatus", encode_csr(F3_RW, csr_pkg::ADDR_MSTATUS, 5'd4, 5'd11),
                32'hffff_ffff, 4'b1001);
        add_row("rci_mstatus", encode_csr(F3_RCI, csr_pkg::ADDR_MSTATUS, 5'h08, 5'd12),
                32'd0, 4'b1001);
        add_row("rs_mstatus", encode_csr(F3_RS, csr_pkg::ADDR_MSTATUS, 5'd5, 5'd13),
                32'd0, 4'b1101);
        add_row("rc_mstatus_all", encode_csr(F3_RC, csr_pkg::ADDR_MSTATUS, 5'd6, 5'd14),
                32'hffff_ffff, 4'b1001);
        add_row("rw_mepc_rd0", encode_csr(F3_RW, csr_pkg::ADDR_MEPC, 5'd7, 5'd0),
                32'h1234_5677, 4'b1001);  // no write-back for x0
        add_row("rs_mepc_read", encode_csr(F3_RS, csr_pkg::ADDR_MEPC, 5'd0, 5'd15),
                32'd0, 4'b1001);
        add_row("rwi_mtvec", encode_csr(F3_RWI, csr_pkg::ADDR_MTVEC, 5'h17, 5'd16),
                32'd0, 4'b1001);
        add_row("int_rw_mtvec", encode_csr(F3_RW, csr_pkg::ADDR_MTVEC, 5'd8, 5'd17),
                32'd0, 4'b1111);
        add_row("read_mtvec_after_int", encode_csr(F3_RS, csr_pkg::ADDR_MTVEC, 5'd0, 5'd18),
                32'd0, 4'b1001);
        add_row("rw_mcause", encode_csr(F3_RW, csr_pkg::ADDR_MCAUSE, 5'd9, 5'd19),
                32'h8000_000b, 4'b1001);
        add_row("hold_rw_mcause", encode_csr(F3_RW, csr_pkg::ADDR_MCAUSE, 5'd10, 5'd20),
                32'h5555_5555, 4'b1000);  // dropped while ready is low
        add_row("hold_rw_mscratch", encode_csr(F3_RW, csr_pkg::ADDR_MSCRATCH, 5'd11, 5'd21),
                32'd0, 4'b1100);
        add_row("read_mcause", encode_csr(F3_RS, csr_pkg::ADDR_MCAUSE, 5'd0, 5'd22),
                32'd0, 4'b1001);
        add_row("read_mscratch", encode_csr(F3_RS, csr_pkg::ADDR_MSCRATCH, 5'd0, 5'd23),
                32'd0, 4'b1001);
        add_row("rs_unknown", encode_csr(F3_RS, 12'h7c0, 5'd0, 5'd24), 32'd0, 4'b1001);
        add_row("rw_unknown", encode_csr(F3_RW, 12'h7c0, 5'd12, 5'd25), 32'd0, 4'b1101);
        add_row("rs_unknown_again", encode_csr(F3_RS, 12'h7c0, 5'd0, 5'd26), 32'd0, 4'b1001);
        add_row("addi_not_system", 32'h0050_0993, 32'hffff_ffff, 4'b1001);
        add_row("ecall_not_csr", 32'h0000_0073, 32'hffff_ffff, 4'b1001);
        add_row("rw_mscratch_no_valid", encode_csr(F3_RW, csr_pkg::ADDR_MSCRATCH, 5'd13, 5'd28),
                32'hdead_beef, 4'b0001);  // instr_valid_i low
        add_row("rs_mscratch_final", encode_csr(F3_RS, csr_pkg::ADDR_MSCRATCH, 5'd0, 5'd27),
                32'd0, 4'b1001);
        for (int i = 0; i < row_instr.size(); i++)
            model_step(i);
    endtask

    task automatic drive_row(input int i);
        instr_valid_i = row_vld[i];
        instr_i       = row_instr[i];
        rs1_data_i    = row_rs1[i];
        int_assert_i  = row_int[i];
        wb_ready_i    = row_rdy[i];
    endtask

    task automatic check_outputs(input int i);
        checks += 4;
        assert (reg_wdata_o == exp_wdata[i]) else begin
            $display("error %s reg_wdata_o expected %h actual %h",
                     row_name[i], exp_wdata[i], reg_wdata_o);
            errors++;
        end
        assert (reg_waddr_o == exp_waddr[i]) else begin
            $display("error %s reg_waddr_o expected %0d actual %0d",
                     row_name[i], exp_waddr[i], reg_waddr_o);
            errors++;
        end
        assert (reg_we_o == exp_we[i]) else begin
            $display("error %s reg_we_o expected %b actual %b",
                     row_name[i], exp_we[i], reg_we_o);
            errors++;
        end
        assert (csr_stall_o == exp_stall[i]) else begin
            $display("error %s csr_stall_o expected %b actual %b",
                     row_name[i], exp_stall[i], csr_stall_o);
            errors++;
        end
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_done);
        cycle_limit = row_instr.size() + 16 + 20;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d cycles without finishing", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = 32'd0;
        rs1_data_i    = 32'd0;
        int_assert_i  = 1'b0;
        wb_ready_i    = 1'b1;
        lfsr          = 32'd2;  // seed
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        m_csr         = '{default: 32'd0};
        m_reg_wdata   = 32'd0;
        m_reg_waddr   = 5'd0;
        m_reg_we      = 1'b0;
        m_csr_we      = 1'b0;
        m_csr_waddr   = 12'd0;
        m_csr_wdata   = 32'd0;
        build_table();
        table_done = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset_i = 1'b0;
        for (int i = 0; i < row_instr.size(); i++) begin
            drive_row(i);
            @(posedge clk);
            #2;  // sample before the next row is driven
            check_outputs(i);
        end
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== csr_sub.f ====
src/csr_pkg.sv
src/csr_req_if.sv
src/csr_decode.sv
src/csr_regfile.sv
src/exu_csr_unit.sv
src/csr_top.sv
tb/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module csr_tb -f csr_sub.f -o csr_sim \
    && ./obj_dir/csr_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation did not pass"; exit 1; }
